//--- hdl/spi_consts.svh
// ----------------------------------------
// register map and buffer sizing for the
// camera SPI register block, include where
// addresses or the buffer depth are needed
// ----------------------------------------

`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// register addresses, first byte of a transaction
`define SPI_ADDR_CHIP_ID 8'hDB
`define SPI_ADDR_IMAGE_READ 8'h20
`define SPI_ADDR_IMAGE_CLEAR 8'h22

// value returned by the chip ID register
`define CHIP_ID_VALUE 8'h81

// image buffer holds 2**N bytes
`define IMAGE_BUFFER_DEPTH_LOG2 7

`endif

//--- hdl/spi_pkg.sv
// ----------------------------------------
// types shared between the SPI peripheral,
// the register selector and the buffer
// ----------------------------------------

`default_nettype none

package spi_pkg;

    typedef logic [7:0] spi_byte_t;

    // peripheral to selector, one transaction at a time
    typedef struct packed {
        spi_byte_t address;
        logic address_valid;
        spi_byte_t data;
        logic data_valid;
        // select low and address byte received
        logic active;
    } spi_cmd_t;

    // selector to peripheral, one answer per valid pulse
    typedef struct packed {
        spi_byte_t data;
        logic valid;
    } spi_resp_t;

endpackage

`default_nettype wire

//--- hdl/readout_counter.sv
// ----------------------------------------
// read pointer into the image buffer for
// one SPI transaction, flags bytes beyond
// the current fill level
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module readout_counter (
    input logic clock_18MHz_oscillator,
    input logic arst_n,
    input logic read_step,
    input logic read_restart,
    input logic [`IMAGE_BUFFER_DEPTH_LOG2:0] fill_level,
    output logic [`IMAGE_BUFFER_DEPTH_LOG2:0] read_address,
    output logic past_end
);

    localparam logic [`IMAGE_BUFFER_DEPTH_LOG2:0] buffer_depth =
        1 << `IMAGE_BUFFER_DEPTH_LOG2;

    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            read_address <= '0;
        end else if (read_restart) begin
            read_address <= '0;
        end else if (read_step && read_address < buffer_depth) begin
            // stops at depth, never wraps back to stale bytes
            read_address <= read_address + 1'b1;
        end
    end

    assign past_end = (read_address >= fill_level);

endmodule

`default_nettype wire

//--- hdl/image_buffer.sv
// ----------------------------------------
// 128 byte camera buffer. fills from the
// pixel stream until full, read back by
// address with one cycle of latency
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module image_buffer (
    input logic clock_18MHz_oscillator,
    input logic arst_n,
    input spi_pkg::spi_byte_t pixel,
    input logic pixel_valid,
    output logic pixel_ready,
    input logic clear,
    input logic [`IMAGE_BUFFER_DEPTH_LOG2:0] read_address,
    output spi_pkg::spi_byte_t read_data,
    output logic [`IMAGE_BUFFER_DEPTH_LOG2:0] fill_level
);

    import spi_pkg::*;

    localparam logic [`IMAGE_BUFFER_DEPTH_LOG2:0] buffer_depth =
        1 << `IMAGE_BUFFER_DEPTH_LOG2;

    spi_byte_t memory [0:(1 << `IMAGE_BUFFER_DEPTH_LOG2) - 1];

    // write pointer, one bit wider than the index so full is visible
    logic [`IMAGE_BUFFER_DEPTH_LOG2:0] write_pointer;
    logic write_enable;

    assign pixel_ready = (write_pointer != buffer_depth);

    // pixel accepted alongside a clear is lost
    assign write_enable = pixel_valid && pixel_ready && !clear;

    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            write_pointer <= '0;
        end else if (clear) begin
            write_pointer <= '0;
        end else if (write_enable) begin
            write_pointer <= write_pointer + 1'b1;
        end
    end

    assign fill_level = write_pointer;

    // simple dual port memory, write side
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (write_enable) begin
            memory[write_pointer[`IMAGE_BUFFER_DEPTH_LOG2-1:0]] <= pixel;
        end
    end

    // read side, registered output
    // a saturated address wraps here but the selector masks it with past_end
    always_ff @(posedge clock_18MHz_oscillator) begin
        read_data <= memory[read_address[`IMAGE_BUFFER_DEPTH_LOG2-1:0]];
    end

endmodule

`default_nettype wire

//--- hdl/subperipheral_selector.sv
// ----------------------------------------
// decodes the transaction address and
// answers every byte from chip ID, image
// read port, buffer control or FF default
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module subperipheral_selector (
    input logic clock_18MHz_oscillator,
    input logic arst_n,
    input spi_pkg::spi_cmd_t cmd,
    output spi_pkg::spi_resp_t resp,
    output logic read_step,
    output logic read_restart,
    output logic clear,
    input spi_pkg::spi_byte_t read_data,
    input logic past_end,
    input logic [`IMAGE_BUFFER_DEPTH_LOG2:0] fill_level
);

    import spi_pkg::*;

    spi_byte_t address_q;
    spi_byte_t target;
    logic pulse;
    logic is_read;

    // chip ID and control answer after one cycle
    logic fast_valid;
    spi_byte_t fast_data;

    // read port needs two cycles, registered memory
    logic read_pending;
    logic read_valid;

    // address byte decodes itself, later bytes use the latched copy
    assign target = cmd.address_valid ? cmd.address : address_q;
    assign pulse = cmd.address_valid | (cmd.data_valid & cmd.active);
    assign is_read = (target == `SPI_ADDR_IMAGE_READ);

    assign read_restart = cmd.address_valid && is_read;
    assign read_step = cmd.data_valid && cmd.active && is_read;
    assign clear = cmd.address_valid && (cmd.address == `SPI_ADDR_IMAGE_CLEAR);

    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            address_q <= 8'h00;
            fast_valid <= 1'b0;
            read_pending <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            if (cmd.address_valid) begin
                address_q <= cmd.address;
            end
            fast_valid <= pulse && !is_read;
            read_pending <= pulse && is_read;
            read_valid <= read_pending;
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        case (target)
            `SPI_ADDR_CHIP_ID: fast_data <= `CHIP_ID_VALUE;
            `SPI_ADDR_IMAGE_CLEAR: fast_data <= spi_byte_t'(fill_level);
            default: fast_data <= 8'hFF;
        endcase
    end

    always_comb begin
        resp.valid = fast_valid | read_valid;
        if (read_valid) begin
            resp.data = past_end ? 8'h00 : read_data;
        end else begin
            resp.data = fast_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_peripheral.sv
// ----------------------------------------
// SPI mode 0 target. synchronizes the pins,
// turns the first byte into an address and
// later bytes into data pulses, and shifts
// the selector's answers out on CIPO
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module spi_peripheral (
    input logic clock_18MHz_oscillator,
    input logic arst_n,
    input logic spi_select,
    input logic spi_clock,
    input logic spi_copi,
    output logic spi_cipo,
    output spi_pkg::spi_cmd_t cmd,
    input spi_pkg::spi_resp_t resp
);

    import spi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_address,
        st_data
    } state_t;

    state_t state;

    // two-flop synchronizers, bit 1 is the safe one
    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] copi_sync;
    logic clock_prev;
    logic clock_rise;
    logic clock_fall;

    logic [2:0] bit_count;
    spi_byte_t in_shift;
    spi_byte_t out_shift;
    spi_byte_t next_byte;
    spi_byte_t address_reg;
    spi_byte_t data_reg;
    logic address_pulse;
    logic data_pulse;
    logic byte_done;

    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            select_sync <= 2'b11;
            clock_sync <= 2'b00;
            copi_sync <= 2'b00;
            clock_prev <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync <= {clock_sync[0], spi_clock};
            copi_sync <= {copi_sync[0], spi_copi};
            clock_prev <= clock_sync[1];
        end
    end

    assign clock_rise = clock_sync[1] & ~clock_prev;
    assign clock_fall = ~clock_sync[1] & clock_prev;

    // eighth rising edge of a byte
    assign byte_done = clock_rise && (bit_count == 3'd7);

    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            bit_count <= 3'd0;
            in_shift <= 8'h00;
            address_reg <= 8'h00;
            data_reg <= 8'h00;
            address_pulse <= 1'b0;
            data_pulse <= 1'b0;
        end else begin
            address_pulse <= 1'b0;
            data_pulse <= 1'b0;

            if (select_sync[1]) begin
                // select high ends whatever was going on
                state <= st_idle;
                bit_count <= 3'd0;
            end else begin
                case (state)
                    st_idle: begin
                        state <= st_address;
                        bit_count <= 3'd0;
                    end
                    default: begin
                        if (clock_rise) begin
                            in_shift <= {in_shift[6:0], copi_sync[1]};
                            bit_count <= bit_count + 3'd1;
                        end
                        if (byte_done && state == st_address) begin
                            address_reg <= {in_shift[6:0], copi_sync[1]};
                            address_pulse <= 1'b1;
                            state <= st_data;
                        end else if (byte_done) begin
                            data_reg <= {in_shift[6:0], copi_sync[1]};
                            data_pulse <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // answer for the next byte, FF unless the selector responds in time
    always_ff @(posedge clock_18MHz_oscillator or negedge arst_n) begin
        if (!arst_n) begin
            next_byte <= 8'hFF;
            out_shift <= 8'hFF;
        end else if (select_sync[1]) begin
            next_byte <= 8'hFF;
            out_shift <= 8'hFF;
        end else begin
            if (resp.valid) begin
                next_byte <= resp.data;
            end else if (byte_done) begin
                next_byte <= 8'hFF;
            end

            // falling edge at a byte boundary presents the new MSB
            if (clock_fall && bit_count == 3'd0) begin
                out_shift <= next_byte;
            end else if (clock_fall) begin
                out_shift <= {out_shift[6:0], 1'b1};
            end
        end
    end

    assign spi_cipo = out_shift[7];

    always_comb begin
        cmd.address = address_reg;
        cmd.address_valid = address_pulse;
        cmd.data = data_reg;
        cmd.data_valid = data_pulse;
        cmd.active = (state == st_data);
    end

endmodule

`default_nettype wire

//--- hdl/spi_camera_top.sv
// ----------------------------------------
// register side of the camera FPGA. SPI
// host reads chip ID and image buffer,
// camera bytes arrive on a byte stream
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_camera_top (
    input logic clock_18MHz_oscillator,
    input logic arst_n,
    input logic spi_select,
    input logic spi_clock,
    input logic spi_copi,
    output logic spi_cipo,
    input spi_pkg::spi_byte_t pixel,
    input logic pixel_valid,
    output logic pixel_ready
);

    import spi_pkg::*;

    spi_cmd_t cmd;
    spi_resp_t resp;

    logic read_step;
    logic read_restart;
    logic clear;
    logic past_end;
    spi_byte_t read_data;
    logic [`IMAGE_BUFFER_DEPTH_LOG2:0] read_address;
    logic [`IMAGE_BUFFER_DEPTH_LOG2:0] fill_level;

    spi_peripheral spi_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .arst_n(arst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_copi(spi_copi),
        .spi_cipo(spi_cipo),
        .cmd(cmd),
        .resp(resp)
    );

    subperipheral_selector subperipheral_selector (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .arst_n(arst_n),
        .cmd(cmd),
        .resp(resp),
        .read_step(read_step),
        .read_restart(read_restart),
        .clear(clear),
        .read_data(read_data),
        .past_end(past_end),
        .fill_level(fill_level)
    );

    readout_counter readout_counter (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .arst_n(arst_n),
        .read_step(read_step),
        .read_restart(read_restart),
        .fill_level(fill_level),
        .read_address(read_address),
        .past_end(past_end)
    );

    image_buffer image_buffer (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .arst_n(arst_n),
        .pixel(pixel),
        .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready),
        .clear(clear),
        .read_address(read_address),
        .read_data(read_data),
        .fill_level(fill_level)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// ----------------------------------------
// testbench clock with a 20 ns period and
// a reset held low for the first 10 cycles
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // release a little after the edge, away from the flops
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clock);
        #2;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_spi_camera.sv
// ----------------------------------------
// testbench for the camera SPI register
// block. drives SPI transactions and the
// pixel stream, checks every CIPO byte
// against a model of the buffer
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module tb_spi_camera;

    import spi_pkg::*;

    localparam int half_period = 5;
    localparam int byte_gap = 10;
    localparam int ready_timeout = 16;
    localparam int buffer_depth = 1 << `IMAGE_BUFFER_DEPTH_LOG2;

    logic clock_18MHz_oscillator;
    logic arst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_copi;
    logic spi_cipo;
    spi_byte_t pixel;
    logic pixel_valid;
    logic pixel_ready;

    logic [31:0] lfsr_state;
    spi_byte_t model_buffer [0:buffer_depth-1];
    int model_fill;

    // bytes waiting for the compare process
    spi_byte_t check_address [$];
    int check_index [$];
    spi_byte_t check_value [$];
    spi_byte_t expected_byte;

    int error_count;
    int check_count;
    int tests_run;
    int tests_failed;
    int errors_before;
    int accepted;
    int guard;
    spi_byte_t cut_tx [$];
    spi_byte_t cut_rx [$];

    tb_clock_gen clock_gen (
        .clock(clock_18MHz_oscillator),
        .arst_n(arst_n)
    );

    spi_camera_top dut (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .arst_n(arst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_copi(spi_copi),
        .spi_cipo(spi_cipo),
        .pixel(pixel),
        .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready)
    );

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        int n;
        value = 32'h0;
        for (n = 0; n < count; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // byte 0 carries the address so data byte k answers for buffer byte k-1
    function automatic spi_byte_t expected_cipo(input spi_byte_t address, input int index,
            input spi_byte_t contents [0:buffer_depth-1], input int fill);
        if (index == 0) begin
            return 8'hFF;
        end
        case (address)
            `SPI_ADDR_CHIP_ID: return `CHIP_ID_VALUE;
            `SPI_ADDR_IMAGE_READ: begin
                if (index - 1 < fill) begin
                    return contents[index - 1];
                end
                return 8'h00;
            end
            // first data byte reports the fill level from before the clear
            `SPI_ADDR_IMAGE_CLEAR: return (index == 1) ? spi_byte_t'(fill) : 8'h00;
            default: return 8'hFF;
        endcase
    endfunction

    always @(posedge clock_18MHz_oscillator) begin
        while (check_value.size() > 0) begin
            expected_byte = expected_cipo(check_address[0], check_index[0], model_buffer,
                model_fill);
            check_count++;
            if (check_value[0] !== expected_byte) begin
                error_count++;
                $display("[ERROR] %0t: address %h byte %0d expected %h got %h", $time,
                    check_address[0], check_index[0], expected_byte, check_value[0]);
            end
            void'(check_address.pop_front());
            void'(check_index.pop_front());
            void'(check_value.pop_front());
        end
    end

    task automatic wait_cycles(input int count);
        if (count > 0) begin
            repeat (count) @(posedge clock_18MHz_oscillator);
            #2;
        end
    endtask

    // mode 0 host that raises select after cut_after bits
    task automatic spi_transfer(input spi_byte_t tx [$], input int cut_after,
            output spi_byte_t rx [$]);
        spi_byte_t received;
        int bit_index;
        int bits_sent;
        rx = {};
        received = 8'h00;
        bits_sent = 0;
        spi_select = 1'b0;
        wait_cycles(half_period);
        foreach (tx[n]) begin
            for (bit_index = 7; bit_index >= 0; bit_index--) begin
                if (bits_sent != cut_after) begin
                    spi_copi = tx[n][bit_index];
                    wait_cycles(half_period);
                    received[bit_index] = spi_cipo;
                    spi_clock = 1'b1;
                    bits_sent++;
                    if (bit_index > 0 && bits_sent != cut_after) begin
                        wait_cycles(half_period);
                        spi_clock = 1'b0;
                    end
                end
            end
            if (bits_sent != cut_after) begin
                // room for the answer before the next falling edge
                wait_cycles(byte_gap);
                spi_clock = 1'b0;
                rx.push_back(received);
            end
        end
        wait_cycles(half_period);
        spi_select = 1'b1;
        wait_cycles(2);
        spi_clock = 1'b0;
        spi_copi = 1'b0;
        wait_cycles(byte_gap);
    endtask

    // hand received bytes to the compare process
    task automatic queue_checks(input spi_byte_t address, input spi_byte_t rx [$]);
        foreach (rx[n]) begin
            check_address.push_back(address);
            check_index.push_back(n);
            check_value.push_back(rx[n]);
        end
    endtask

    task automatic run_transaction(input spi_byte_t address, input int data_count);
        spi_byte_t tx [$];
        spi_byte_t rx [$];
        int wait_count;
        tx.push_back(address);
        repeat (data_count) tx.push_back(8'h00);
        spi_transfer(tx, -1, rx);
        if (rx.size() != tx.size()) begin
            error_count++;
            $display("host returned %0d bytes for a %0d byte transaction", rx.size(),
                tx.size());
        end
        queue_checks(address, rx);
        wait_count = 0;
        while (check_value.size() > 0 && wait_count < 20) begin
            @(posedge clock_18MHz_oscillator);
            #2;
            wait_count++;
        end
        if (check_value.size() > 0) begin
            error_count++;
            $display("timed out waiting for the compare process to check the bytes");
        end
    endtask

    task automatic stream_bytes(input int count, input bit random_gaps, output int taken);
        logic [31:0] bits;
        int wait_count;
        int n;
        taken = 0;
        for (n = 0; n < count; n++) begin
            if (random_gaps) begin
                draw_bits(2, bits);
                wait_cycles(int'(bits));
            end
            draw_bits(8, bits);
            pixel = bits[7:0];
            pixel_valid = 1'b1;
            wait_count = 0;
            while (pixel_ready !== 1'b1 && wait_count < ready_timeout) begin
                wait_cycles(1);
                wait_count++;
            end
            if (pixel_ready === 1'b1) begin
                // accepting edge
                wait_cycles(1);
                if (model_fill < buffer_depth) begin
                    model_buffer[model_fill] = pixel;
                    model_fill++;
                end
                taken++;
            end
            pixel_valid = 1'b0;
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                error_count - errors_at_start);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_copi = 1'b0;
        pixel = 8'h00;
        pixel_valid = 1'b0;
        lfsr_state = 32'h773a_b840;
        model_fill = 0;
        error_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        foreach (model_buffer[n]) model_buffer[n] = 8'h00;

        guard = 0;
        while (arst_n !== 1'b1 && guard < 50) begin
            @(posedge clock_18MHz_oscillator);
            guard++;
        end
        #2;
        if (arst_n !== 1'b1) begin
            error_count++;
            $display("reset was never released");
        end
        wait_cycles(2);

        errors_before = error_count;
        check_bit(spi_cipo, 1'b1, "cipo after reset");
        check_bit(pixel_ready, 1'b1, "pixel_ready after reset");
        run_transaction(`SPI_ADDR_IMAGE_CLEAR, 1);
        model_fill = 0;
        finish_test("reset state", errors_before);

        errors_before = error_count;
        run_transaction(`SPI_ADDR_CHIP_ID, 2);
        run_transaction(8'h55, 2);
        finish_test("chip id and unused address", errors_before);

        errors_before = error_count;
        stream_bytes(20, 1'b0, accepted);
        if (accepted != 20) begin
            error_count++;
            $display("[ERROR] %0t: stream accepted %0d of 20 bytes", $time, accepted);
        end
        wait_cycles(2);
        run_transaction(`SPI_ADDR_IMAGE_READ, 24);
        run_transaction(`SPI_ADDR_IMAGE_READ, 3);
        finish_test("stream and read back", errors_before);

        errors_before = error_count;
        run_transaction(`SPI_ADDR_IMAGE_CLEAR, 1);
        model_fill = 0;
        stream_bytes(140, 1'b1, accepted);
        if (accepted != buffer_depth) begin
            error_count++;
            $display("[ERROR] %0t: stream accepted %0d of 140 bytes", $time, accepted);
        end
        wait_cycles(5);
        check_bit(pixel_ready, 1'b0, "pixel_ready with a full buffer");
        run_transaction(`SPI_ADDR_IMAGE_READ, buffer_depth + 1);
        check_bit(pixel_ready, 1'b0, "pixel_ready after full readback");
        run_transaction(`SPI_ADDR_IMAGE_CLEAR, 1);
        model_fill = 0;
        check_bit(pixel_ready, 1'b1, "pixel_ready after clear");
        run_transaction(`SPI_ADDR_IMAGE_CLEAR, 1);
        finish_test("full buffer and clear", errors_before);

        errors_before = error_count;
        cut_tx = {};
        cut_tx.push_back(`SPI_ADDR_CHIP_ID);
        cut_tx.push_back(8'h00);
        spi_transfer(cut_tx, 12, cut_rx);
        if (cut_rx.size() != 1) begin
            error_count++;
            $display("host returned %0d bytes before the cut instead of 1", cut_rx.size());
        end
        queue_checks(`SPI_ADDR_CHIP_ID, cut_rx);
        check_bit(spi_cipo, 1'b1, "cipo after select raised mid byte");
        cut_tx = {};
        cut_tx.push_back(`SPI_ADDR_IMAGE_READ);
        spi_transfer(cut_tx, 5, cut_rx);
        if (cut_rx.size() != 0) begin
            error_count++;
            $display("host returned %0d bytes from a cut address byte", cut_rx.size());
        end
        run_transaction(`SPI_ADDR_CHIP_ID, 2);
        run_transaction(`SPI_ADDR_IMAGE_READ, 2);
        finish_test("aborted transaction", errors_before);

        $display("tests run %0d, tests failed %0d, bytes checked %0d, errors %0d",
            tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/readout_counter.sv
hdl/image_buffer.sv
hdl/subperipheral_selector.sv
hdl/spi_peripheral.sv
hdl/spi_camera_top.sv
testbench/tb_clock_gen.sv
testbench/tb_spi_camera.sv

//--- run_sim.sh
#!/bin/sh
# builds the camera SPI testbench with Verilator and runs it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_spi_camera -o tb_spi_camera
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_spi_camera > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$log_file"; then
    exit 0
fi

echo "pass message not found in $log_file"
exit 1
